/* rtl/lc3b_types_pkg.sv */
package lc3b_types_pkg;

	// basic LC-3b widths.
	localparam int lc3b_word_width = 16;
	localparam int lc3b_line_width = 128;
	localparam int line_offset_width = 4; // byte offset inside a 16-byte line.

	// a byte address.
	typedef logic [lc3b_word_width-1:0] lc3b_word;

	// one full cache line, eight words.
	typedef logic [lc3b_line_width-1:0] lc3b_cacheline;

	// address bits 15 to 4, the line number.
	typedef logic [lc3b_word_width-line_offset_width-1:0] lc3b_line_addr;

endpackage : lc3b_types_pkg

/* rtl/victim_cache_pkg.sv */
package victim_cache_pkg;

	// geometry of the victim buffer.
	localparam int num_entries = 4;
	localparam int entry_index_width = 2;

	// names one of the entries.
	typedef logic [entry_index_width-1:0] entry_index;

	// request decoded from the upstream bus cycle.
	typedef enum logic [1:0]
	{
		op_idle,   // no cycle in progress.
		op_fetch,  // L1 miss, read a line.
		op_insert  // L1 eviction, write a line.
	} vc_op;

	// controller states.
	typedef enum logic [2:0]
	{
		st_idle,
		st_respond,   // hit or free insert, ack next edge.
		st_writeback, // victim line going out to memory.
		st_mem_read,  // miss forwarded to memory.
		st_done       // ack given, wait for strobe to drop.
	} vc_state;

endpackage : victim_cache_pkg

/* rtl/victim_lookup.sv */
`timescale 1ns/1ps

module victim_lookup
(
	input  logic                          buf_mem_resp,
	input  logic                          rst_n,
	input  logic                          buf_cyc,
	input  logic                          buf_stb,
	input  logic                          buf_we,
	input  lc3b_types_pkg::lc3b_word      buf_adr,
	input  logic                          fill_en,
	input  logic                          clear_en,
	input  victim_cache_pkg::entry_index  fill_index,
	input  victim_cache_pkg::entry_index  clear_index,
	output victim_cache_pkg::vc_op        op,
	output logic                          hit,
	output logic                          free_valid,
	output victim_cache_pkg::entry_index  hit_index,
	output victim_cache_pkg::entry_index  free_index,
	output victim_cache_pkg::entry_index  victim_index,
	output lc3b_types_pkg::lc3b_line_addr evict_tag
);

	import lc3b_types_pkg::*;
	import victim_cache_pkg::*;

	lc3b_line_addr            tags [num_entries];
	logic [num_entries-1:0]   valid;
	entry_index               victim_ptr;   // round-robin replacement pointer.
	lc3b_line_addr            line_addr;

	assign line_addr = buf_adr[lc3b_word_width-1:line_offset_width];

	// bus cycle to opcode.
	assign op = (buf_cyc && buf_stb) ? (buf_we ? op_insert : op_fetch) : op_idle;

	// tag match and lowest free slot, scanning down so index 0 wins.
	always_comb
	begin
		hit = 1'b0;
		hit_index = '0;
		free_valid = 1'b0;
		free_index = '0;
		for (int i = num_entries - 1; i >= 0; i--)
		begin
			if (valid[i] && (tags[i] == line_addr))
			begin
				hit = 1'b1;
				hit_index = entry_index'(i);
			end
			if (!valid[i])
			begin
				free_valid = 1'b1;
				free_index = entry_index'(i);
			end
		end
	end

	assign victim_index = victim_ptr;
	assign evict_tag = tags[victim_ptr]; // line address for the writeback.

	always_ff @(posedge buf_mem_resp)
	begin
		if (!rst_n)
		begin
			valid <= '0;
			victim_ptr <= '0;
		end
		else
		begin
			if (clear_en)
				valid[clear_index] <= 1'b0; // line moved back to L1.
			if (fill_en)
				valid[fill_index] <= 1'b1;
			if (fill_en && (fill_index == victim_ptr) && !free_valid)
				victim_ptr <= victim_ptr + entry_index'(1);
		end
	end

	always_ff @(posedge buf_mem_resp)
	begin
		if (fill_en)
			tags[fill_index] <= line_addr;
	end

endmodule : victim_lookup

/* rtl/victim_control.sv */
`timescale 1ns/1ps

module victim_control
(
	input  logic                          buf_mem_resp,
	input  logic                          rst_n,
	input  victim_cache_pkg::vc_op        op,
	input  logic                          hit,
	input  victim_cache_pkg::entry_index  hit_index,
	input  logic                          free_valid,
	input  victim_cache_pkg::entry_index  free_index,
	input  victim_cache_pkg::entry_index  victim_index,
	input  lc3b_types_pkg::lc3b_line_addr evict_tag,
	input  lc3b_types_pkg::lc3b_word      buf_adr,
	input  logic                          mem_ack,
	output logic                          buf_ack,
	output logic                          mem_cyc,
	output logic                          mem_stb,
	output logic                          mem_we,
	output lc3b_types_pkg::lc3b_word      mem_adr,
	output logic                          fill_en,
	output logic                          clear_en,
	output logic                          mem_capture,
	output logic                          sel_mem,
	output victim_cache_pkg::entry_index  fill_index,
	output victim_cache_pkg::entry_index  clear_index,
	output victim_cache_pkg::entry_index  sel_index
);

	import lc3b_types_pkg::*;
	import victim_cache_pkg::*;

	vc_state    state;
	entry_index idx_q; // entry chosen when the request was accepted.

	// update commands land on the same edge that raises buf_ack.
	assign fill_en = ((state == st_respond) && (op == op_insert)) ||
	                 ((state == st_writeback) && mem_ack);
	assign clear_en = (state == st_respond) && (op == op_fetch);
	assign mem_capture = (state == st_mem_read) && mem_ack;

	assign fill_index = idx_q;
	assign clear_index = idx_q;
	assign sel_index = idx_q;

	always_ff @(posedge buf_mem_resp)
	begin
		if (!rst_n)
		begin
			state <= st_idle;
			buf_ack <= 1'b0;
			mem_cyc <= 1'b0;
			mem_stb <= 1'b0;
			mem_we <= 1'b0;
			sel_mem <= 1'b0;
		end
		else
		begin
			case (state)
				st_idle:
				begin
					if (op == op_fetch)
					begin
						sel_mem <= !hit; // misses return the memory line.
						if (hit)
							state <= st_respond;
						else
						begin
							state <= st_mem_read;
							mem_cyc <= 1'b1;
							mem_stb <= 1'b1;
							mem_we <= 1'b0;
						end
					end
					else if (op == op_insert)
					begin
						sel_mem <= 1'b0;
						if (hit || free_valid)
							state <= st_respond;
						else
						begin
							state <= st_writeback; // full, evict first.
							mem_cyc <= 1'b1;
							mem_stb <= 1'b1;
							mem_we <= 1'b1;
						end
					end
				end
				st_respond:
				begin
					buf_ack <= 1'b1;
					state <= st_done;
				end
				st_writeback, st_mem_read:
				begin
					if (mem_ack)
					begin
						mem_cyc <= 1'b0;
						mem_stb <= 1'b0;
						mem_we <= 1'b0;
						buf_ack <= 1'b1;
						state <= st_done;
					end
				end
				st_done:
				begin
					buf_ack <= 1'b0; // single-cycle ack.
					if (op == op_idle)
						state <= st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

	// entry and memory address are latched as the request is accepted.
	always_ff @(posedge buf_mem_resp)
	begin
		if (state == st_idle)
		begin
			if (hit)
				idx_q <= hit_index;
			else if ((op == op_insert) && free_valid)
				idx_q <= free_index;
			else
				idx_q <= victim_index;
			if ((op == op_insert) && !hit && !free_valid)
				mem_adr <= {evict_tag, {line_offset_width{1'b0}}};
			else
				mem_adr <= {buf_adr[lc3b_word_width-1:line_offset_width],
				            {line_offset_width{1'b0}}};
		end
	end

endmodule : victim_control

/* rtl/victim_return.sv */
`timescale 1ns/1ps

module victim_return
(
	input  logic                          buf_mem_resp,
	input  logic                          fill_en,
	input  victim_cache_pkg::entry_index  fill_index,
	input  lc3b_types_pkg::lc3b_cacheline buf_wdata,
	input  logic                          mem_capture,
	input  lc3b_types_pkg::lc3b_cacheline mem_rdata,
	input  victim_cache_pkg::entry_index  sel_index,
	input  logic                          sel_mem,
	output lc3b_types_pkg::lc3b_cacheline buf_rdata,
	output lc3b_types_pkg::lc3b_cacheline mem_wdata
);

	import lc3b_types_pkg::*;
	import victim_cache_pkg::*;

	lc3b_cacheline data [num_entries]; // line storage, one per tag.
	lc3b_cacheline mem_line;            // last line read from memory.

	always_ff @(posedge buf_mem_resp)
	begin
		if (fill_en)
			data[fill_index] <= buf_wdata;
	end

	always_ff @(posedge buf_mem_resp)
	begin
		if (mem_capture)
			mem_line <= mem_rdata;
	end

	// upstream sees memory data on a miss, the entry otherwise.
	assign buf_rdata = sel_mem ? mem_line : data[sel_index];

	// the selected entry is the victim during a writeback.
	assign mem_wdata = data[sel_index];

endmodule : victim_return

/* rtl/victim_cache.sv */
`timescale 1ns/1ps

module victim_cache
(
	input  logic                          buf_mem_resp,
	input  logic                          rst_n,
	input  logic                          buf_cyc,
	input  logic                          buf_stb,
	input  logic                          buf_we,
	input  lc3b_types_pkg::lc3b_word      buf_adr,
	input  lc3b_types_pkg::lc3b_cacheline buf_wdata,
	output lc3b_types_pkg::lc3b_cacheline buf_rdata,
	output logic                          buf_ack,
	output logic                          mem_cyc,
	output logic                          mem_stb,
	output logic                          mem_we,
	output lc3b_types_pkg::lc3b_word      mem_adr,
	output lc3b_types_pkg::lc3b_cacheline mem_wdata,
	input  lc3b_types_pkg::lc3b_cacheline mem_rdata,
	input  logic                          mem_ack
);

	import lc3b_types_pkg::*;
	import victim_cache_pkg::*;

	vc_op          op;
	logic          hit, free_valid;
	entry_index    hit_index, free_index, victim_index;
	lc3b_line_addr evict_tag;
	logic          fill_en, clear_en, mem_capture, sel_mem;
	entry_index    fill_index, clear_index, sel_index;

	victim_lookup u_lookup (.buf_mem_resp, .rst_n, .buf_cyc, .buf_stb, .buf_we, .buf_adr,
		.fill_en, .clear_en, .fill_index, .clear_index, .op, .hit, .free_valid,
		.hit_index, .free_index, .victim_index, .evict_tag);

	victim_control u_control (.buf_mem_resp, .rst_n, .op, .hit, .hit_index, .free_valid,
		.free_index, .victim_index, .evict_tag, .buf_adr, .mem_ack, .buf_ack,
		.mem_cyc, .mem_stb, .mem_we, .mem_adr, .fill_en, .clear_en, .mem_capture,
		.sel_mem, .fill_index, .clear_index, .sel_index);

	victim_return u_return (.buf_mem_resp, .fill_en, .fill_index, .buf_wdata,
		.mem_capture, .mem_rdata, .sel_index, .sel_mem, .buf_rdata, .mem_wdata);

endmodule : victim_cache

/* sim/backing_memory.sv */
`timescale 1ns/1ps

module backing_memory
#(
	parameter int latency = 3
)
(
	input  logic                          buf_mem_resp,
	input  logic                          rst_n,
	input  logic                          mem_cyc,
	input  logic                          mem_stb,
	input  logic                          mem_we,
	input  lc3b_types_pkg::lc3b_word      mem_adr,
	input  lc3b_types_pkg::lc3b_cacheline mem_wdata,
	output lc3b_types_pkg::lc3b_cacheline mem_rdata,
	output logic                          mem_ack
);

	import lc3b_types_pkg::*;

	lc3b_cacheline lines [1 << (lc3b_word_width - line_offset_width)];
	int            wait_count;
	lc3b_line_addr line_addr;

	assign line_addr = mem_adr[lc3b_word_width-1:line_offset_width];
	assign mem_rdata = lines[line_addr];

	// line n holds n in every word.
	initial
	begin
		for (int n = 0; n < (1 << (lc3b_word_width - line_offset_width)); n++)
			lines[n] = {8{16'(n)}};
	end

	always_ff @(posedge buf_mem_resp)
	begin
		if (!rst_n)
		begin
			mem_ack <= 1'b0;
			wait_count <= 0;
		end
		else if (mem_ack)
		begin
			mem_ack <= 1'b0; // one-cycle ack.
			wait_count <= 0;
		end
		else if (mem_cyc && mem_stb)
		begin
			if (wait_count == latency - 1)
			begin
				mem_ack <= 1'b1;
				if (mem_we)
					lines[line_addr] <= mem_wdata;
			end
			wait_count <= wait_count + 1;
		end
	end

endmodule : backing_memory

/* sim/victim_cache_tb.sv */
`timescale 1ns/1ps

module victim_cache_tb;

	import lc3b_types_pkg::*;
	import victim_cache_pkg::*;

	localparam int seed = 32'h9d25;
	localparam int mem_latency = 3;
	localparam int total_requests = 214;
	localparam int timeout_cycles = 40 * total_requests;

	logic          buf_mem_resp = 1'b0;
	logic          rst_n;
	logic          buf_cyc, buf_stb, buf_we;
	lc3b_word      buf_adr;
	lc3b_cacheline buf_wdata, buf_rdata;
	logic          buf_ack;
	logic          mem_cyc, mem_stb, mem_we, mem_ack;
	lc3b_word      mem_adr;
	lc3b_cacheline mem_wdata, mem_rdata;

	int            errors = 0;
	int            test_errors;
	int            cycle_count = 0;

	// results of the last bus request.
	lc3b_cacheline last_rdata, last_wb_data;
	lc3b_word      last_wb_addr;
	logic          last_mem, last_wb;
	int            last_cycles;

	// reference model of the buffer and of memory.
	logic          m_valid [num_entries];
	lc3b_line_addr m_tag [num_entries];
	lc3b_cacheline m_data [num_entries];
	entry_index    m_ptr;
	lc3b_cacheline m_mem [1 << 12];

	victim_cache u_dut (.buf_mem_resp, .rst_n, .buf_cyc, .buf_stb, .buf_we, .buf_adr,
		.buf_wdata, .buf_rdata, .buf_ack, .mem_cyc, .mem_stb, .mem_we, .mem_adr,
		.mem_wdata, .mem_rdata, .mem_ack);

	backing_memory #(.latency(mem_latency)) u_mem (.buf_mem_resp, .rst_n, .mem_cyc,
		.mem_stb, .mem_we, .mem_adr, .mem_wdata, .mem_rdata, .mem_ack);

	always #5 buf_mem_resp = ~buf_mem_resp;

	always @(posedge buf_mem_resp)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles)
		begin
			$display("timeout: the DUT stopped answering after %0d cycles", cycle_count);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	task automatic check_line(input string msg, input lc3b_cacheline got, input lc3b_cacheline exp);
		if (got !== exp)
		begin
			$display("Mismatch at %0t: %s got %h expected %h", $time, msg, got, exp);
			errors++;
		end
	endtask

	task automatic check_word(input string msg, input lc3b_word got, input lc3b_word exp);
		if (got !== exp)
		begin
			$display("Mismatch at %0t: %s got %h expected %h", $time, msg, got, exp);
			errors++;
		end
	endtask

	task automatic check_bit(input string msg, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("Mismatch at %0t: %s got %b expected %b", $time, msg, got, exp);
			errors++;
		end
	endtask

	// one request on the upstream bus, waits for buf_ack.
	task automatic bus_request(input logic we, input lc3b_line_addr line, input lc3b_cacheline wdata);
		@(posedge buf_mem_resp);
		buf_cyc <= 1'b1;
		buf_stb <= 1'b1;
		buf_we <= we;
		buf_adr <= {line, 4'h0};
		buf_wdata <= wdata;
		last_cycles = -1;
		last_mem = 1'b0;
		last_wb = 1'b0;
		do
		begin
			@(posedge buf_mem_resp);
			last_cycles++;
			if (mem_cyc)
				last_mem = 1'b1;
			if (mem_cyc && mem_we && mem_ack)
			begin
				last_wb = 1'b1;
				last_wb_addr = mem_adr;
				last_wb_data = mem_wdata;
			end
		end
		while (!buf_ack);
		last_rdata = buf_rdata;
		check_bit("memory strobe released at ack", mem_stb, 1'b0);
		buf_cyc <= 1'b0;
		buf_stb <= 1'b0;
		buf_we <= 1'b0;
		@(posedge buf_mem_resp); // idle cycle between requests.
		check_bit("ack lasts one cycle", buf_ack, 1'b0);
	endtask

	// runs a request and checks it against the model.
	task automatic access(input logic we, input lc3b_line_addr line, input lc3b_cacheline wdata);
		int            idx;
		logic          full;
		logic          exp_wb;
		lc3b_line_addr wb_line;
		lc3b_cacheline wb_data, exp_rdata;
		idx = -1;
		full = 1'b1;
		exp_wb = 1'b0;
		for (int i = 0; i < num_entries; i++)
			if (m_valid[i] && m_tag[i] == line)
				idx = i;
		for (int i = num_entries - 1; i >= 0; i--)
			if (!m_valid[i])
				full = 1'b0;
		if (we)
		begin
			if (idx < 0)
			begin
				for (int i = num_entries - 1; i >= 0; i--)
					if (!m_valid[i])
						idx = i; // lowest free entry.
				if (idx < 0)
				begin
					idx = int'(m_ptr);
					exp_wb = 1'b1;
					wb_line = m_tag[idx];
					wb_data = m_data[idx];
					m_mem[wb_line] = wb_data;
				end
			end
			m_valid[idx] = 1'b1;
			m_tag[idx] = line;
			m_data[idx] = wdata;
			if (full && entry_index'(idx) == m_ptr)
				m_ptr++;
		end
		else if (idx >= 0)
		begin
			exp_rdata = m_data[idx];
			m_valid[idx] = 1'b0; // hit moves the line back to L1.
		end
		else
			exp_rdata = m_mem[line];
		bus_request(we, line, wdata);
		check_bit("writeback issued", last_wb, exp_wb);
		if (exp_wb && last_wb)
		begin
			check_word("writeback address", last_wb_addr, {wb_line, 4'h0});
			check_line("writeback data", last_wb_data, wb_data);
		end
		if (!we)
			check_line("fetch data", last_rdata, exp_rdata);
	endtask

	task automatic test_done(input string name);
		$display("test %s: %0d errors", name, errors - test_errors);
		test_errors = errors;
	endtask

	task automatic test_fetch_miss();
		access(1'b0, 12'h031, '0);
		check_bit("miss uses memory", last_mem, 1'b1);
		check_line("miss data", last_rdata, {8{16'h0031}});
		access(1'b0, 12'h031, '0);
		check_bit("second miss uses memory", last_mem, 1'b1);
		test_done("fetch_miss");
	endtask

	task automatic test_insert_hit();
		access(1'b1, 12'h040, {8{16'hbeef}});
		access(1'b0, 12'h040, '0);
		check_bit("hit ack after 2 cycles", last_cycles == 2, 1'b1);
		check_bit("hit uses memory", last_mem, 1'b0);
		check_line("hit data", last_rdata, {8{16'hbeef}});
		test_done("insert_hit");
	endtask

	task automatic test_removal();
		access(1'b0, 12'h040, '0);
		check_bit("fetch after hit uses memory", last_mem, 1'b1);
		check_line("fetch after hit data", last_rdata, {8{16'h0040}});
		test_done("removal");
	endtask

	task automatic test_overwrite();
		access(1'b1, 12'h050, {8{16'h1111}});
		access(1'b1, 12'h050, {8{16'h2222}});
		check_bit("overwrite insert uses memory", last_mem, 1'b0);
		access(1'b0, 12'h050, '0);
		check_bit("overwrite hit uses memory", last_mem, 1'b0);
		check_line("overwrite data", last_rdata, {8{16'h2222}});
		test_done("overwrite");
	endtask

	task automatic test_writeback();
		for (int i = 0; i < 5; i++)
			access(1'b1, 12'h060 + 12'(i), {8{16'ha000 + 16'(i)}});
		check_bit("fifth insert writes back", last_wb, 1'b1);
		check_word("writeback address of entry 0", last_wb_addr, 16'h0600);
		check_line("writeback data of entry 0", last_wb_data, {8{16'ha000}});
		access(1'b0, 12'h060, '0);
		check_line("written back line", last_rdata, {8{16'ha000}});
		test_done("writeback");
	endtask

	task automatic test_random();
		lc3b_cacheline wdata;
		for (int n = 0; n < 200; n++)
		begin
			wdata = {$urandom, $urandom, $urandom, $urandom};
			access(1'($urandom), 12'h020 + 12'($urandom % 8), wdata);
		end
		test_done("random");
	endtask

	initial
	begin
		void'($urandom(seed));
		rst_n = 1'b0;
		buf_cyc = 1'b0;
		buf_stb = 1'b0;
		buf_we = 1'b0;
		buf_adr = '0;
		buf_wdata = '0;
		for (int i = 0; i < num_entries; i++)
			m_valid[i] = 1'b0;
		m_ptr = '0;
		for (int n = 0; n < (1 << 12); n++)
			m_mem[n] = {8{16'(n)}};
		test_errors = 0;
		repeat (16) @(posedge buf_mem_resp);
		rst_n <= 1'b1;
		test_fetch_miss();
		test_insert_hit();
		test_removal();
		test_overwrite();
		test_writeback();
		test_random();
		$display("%0d errors in %0d cycles", errors, cycle_count);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule : victim_cache_tb

/* tb.f */
rtl/lc3b_types_pkg.sv
rtl/victim_cache_pkg.sv
rtl/victim_lookup.sv
rtl/victim_control.sv
rtl/victim_return.sv
rtl/victim_cache.sv
sim/backing_memory.sv
sim/victim_cache_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= victim_cache_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
